//--- wbb_pkg.sv
//**********************************************************
// Shared sizes, types and command structs of the L1 data
// cache write-back victim buffer
// Every RTL module takes what it needs by a wildcard import
// The testbench uses the same types to build its stimulus
//**********************************************************

package wbb_pkg;

  // Buffer geometry
  localparam int WBB_ENTRIES    = 4;
  localparam int LINE_BITS      = 128;
  localparam int LINE_ADDR_BITS = 28;
  localparam int TAG_BITS       = 4;
  localparam int WBB_IDX_BITS   = $clog2(WBB_ENTRIES);

  // One full cache line, no byte enables
  typedef logic [LINE_BITS-1:0] dcache_line_t;

  // Line address, byte offset already stripped
  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

  // Tag of one L2 write request
  typedef logic [TAG_BITS-1:0] wbb_tag_t;

  // Free entry count, needs one extra bit to reach WBB_ENTRIES
  typedef logic [WBB_IDX_BITS:0] wbb_free_t;

  // L1 port to buffer
  // add and switch write the line, lookup only reads it
  typedef struct packed {
    logic         add;
    logic         switch;
    logic         lookup;
    line_addr_t   line_addr;
    dcache_line_t line;
  } wbb_l1_cmd_t;

  // L2 master to buffer
  // tag is compared on clear and wake only
  typedef struct packed {
    logic     issue;
    logic     clear;
    logic     wake;
    wbb_tag_t tag;
  } wbb_l2_cmd_t;

  // Buffer state seen by both ports
  typedef struct packed {
    logic      line_hit;
    logic      tag_hit;
    logic      req_available;
    logic      full;
    wbb_free_t free_entries;
  } wbb_status_t;

endpackage

//--- wbb_prio_encoder.sv
//**********************************************************
// Lowest-index priority encoder for the victim buffer
// Turns an entry bit vector into the index of its lowest
// set bit, any_o flags a non-empty vector
//**********************************************************

`timescale 1ns/100ps

module wbb_prio_encoder import wbb_pkg::*; (
  input  logic [WBB_ENTRIES-1:0]  vec_i,
  output logic [WBB_IDX_BITS-1:0] idx_o,
  output logic                    any_o
);

  // Scan from the top so the lowest set bit wins
  always_comb begin
    idx_o = '0;
    for (int i = WBB_ENTRIES - 1; i >= 0; i--) begin
      if (vec_i[i]) begin
        idx_o = WBB_IDX_BITS'(i);
      end
    end
  end

  // Index is only meaningful with any_o high
  assign any_o = |vec_i;

endmodule

//--- wbb_buffer.sv
//**********************************************************
// Victim entry register file of the write-back buffer
// Holds line, address, tag, valid and wait bits per entry
// Compares the L1 line address and the L2 tag, selects the
// free, next-request and hit entries, and applies one
// command per cycle in the order add or switch, issue,
// clear and wake
//**********************************************************

`timescale 1ns/100ps

module wbb_buffer import wbb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  wbb_l1_cmd_t  l1_cmd_i,
  input  wbb_l2_cmd_t  l2_cmd_i,
  input  wbb_tag_t     new_tag_i,
  output logic         l2_cmd_taken_o,
  output dcache_line_t hit_line_o,
  output dcache_line_t req_line_o,
  output line_addr_t   req_addr_o,
  output wbb_status_t  status_o
);

  // Entry payload
  dcache_line_t line_q [WBB_ENTRIES];
  line_addr_t   addr_q [WBB_ENTRIES];
  wbb_tag_t     tag_q  [WBB_ENTRIES];

  // Entry state
  // A set wait bit implies a set valid bit
  logic [WBB_ENTRIES-1:0] valid_q;
  logic [WBB_ENTRIES-1:0] wait_q;

  // Compare and select vectors
  logic [WBB_ENTRIES-1:0] line_hit_vec;
  logic [WBB_ENTRIES-1:0] tag_hit_vec;
  logic [WBB_ENTRIES-1:0] hit_vec;
  logic [WBB_ENTRIES-1:0] ready_vec;

  // Selected entries
  logic [WBB_IDX_BITS-1:0] free_idx;
  logic [WBB_IDX_BITS-1:0] req_idx;
  logic [WBB_IDX_BITS-1:0] hit_idx;
  logic                    free_any;
  logic                    req_any;
  logic                    hit_any;

  // Command arbitration
  logic l1_write;
  logic l1_any;
  logic do_add;
  logic do_switch;
  logic do_issue;
  logic do_clear;
  logic do_wake;

  // Number of entries without the valid bit
  wbb_free_t free_cnt;

  // Line address hit only against valid entries
  // Tag hit only against waiting entries so older tags go stale
  always_comb begin
    for (int k = 0; k < WBB_ENTRIES; k++) begin
      line_hit_vec[k] = valid_q[k] && (addr_q[k] == l1_cmd_i.line_addr);
      tag_hit_vec[k]  = wait_q[k] && (tag_q[k] == l2_cmd_i.tag);
    end
  end

  // Any L1 command owns the hit index for that cycle
  assign l1_write  = l1_cmd_i.add | l1_cmd_i.switch;
  assign l1_any    = l1_write | l1_cmd_i.lookup;
  assign hit_vec   = l1_any ? line_hit_vec : tag_hit_vec;

  // Valid and not yet sent to L2
  assign ready_vec = valid_q & ~wait_q;

  wbb_prio_encoder u_free_enc (
    .vec_i (~valid_q),
    .idx_o (free_idx),
    .any_o (free_any)
  );

  wbb_prio_encoder u_req_enc (
    .vec_i (ready_vec),
    .idx_o (req_idx),
    .any_o (req_any)
  );

  wbb_prio_encoder u_hit_enc (
    .vec_i (hit_vec),
    .idx_o (hit_idx),
    .any_o (hit_any)
  );

  // Priority from add or switch down to issue, clear and wake
  // Lookup only blocks clear and wake since they share the hit index
  assign do_add    = l1_cmd_i.add & free_any;
  assign do_switch = l1_cmd_i.switch & hit_any;
  assign do_issue  = l2_cmd_i.issue & ~l1_write & req_any;
  // Stale tag is consumed but finds no entry
  assign do_clear  = l2_cmd_i.clear & ~l1_any & hit_any;
  assign do_wake   = l2_cmd_i.wake & ~l1_any & hit_any & ~l2_cmd_i.clear;

  // L2 master holds an untaken command for the next cycle
  assign l2_cmd_taken_o = (l2_cmd_i.issue & ~l1_write & req_any) |
                          ((l2_cmd_i.clear | l2_cmd_i.wake) & ~l1_any);

  // Valid and wait bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (do_add) begin
      valid_q[free_idx] <= 1'b1;
      wait_q[free_idx]  <= 1'b0;
    end else if (do_switch) begin
      // New line replaces an in-flight one so the old ack goes stale
      wait_q[hit_idx] <= 1'b0;
    end else if (do_issue) begin
      wait_q[req_idx] <= 1'b1;
    end else if (do_clear) begin
      valid_q[hit_idx] <= 1'b0;
      wait_q[hit_idx]  <= 1'b0;
    end else if (do_wake) begin
      // Entry goes back to the ready set for a retry
      wait_q[hit_idx] <= 1'b0;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (do_add) begin
      line_q[free_idx] <= l1_cmd_i.line;
      addr_q[free_idx] <= l1_cmd_i.line_addr;
    end else if (do_switch) begin
      line_q[hit_idx] <= l1_cmd_i.line;
    end else if (do_issue) begin
      tag_q[req_idx] <= new_tag_i;
    end
  end

  // Read paths
  assign hit_line_o = line_q[hit_idx];
  assign req_line_o = line_q[req_idx];
  assign req_addr_o = addr_q[req_idx];

  // Free entry count
  always_comb begin
    free_cnt = '0;
    for (int k = 0; k < WBB_ENTRIES; k++) begin
      if (!valid_q[k]) begin
        free_cnt = free_cnt + wbb_free_t'(1);
      end
    end
  end

  assign status_o.free_entries  = free_cnt;
  assign status_o.line_hit      = |line_hit_vec;
  assign status_o.tag_hit       = |tag_hit_vec;
  assign status_o.req_available = req_any;
  assign status_o.full          = ~free_any;

  // L1 port must hold back a new line while the buffer is full
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    l1_cmd_i.add |-> !status_o.full)
    else $error("victim buffer add while full");

  // Add only on a miss keeps line addresses unique
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(line_hit_vec))
    else $error("victim buffer holds a line address twice");

endmodule

//--- wbb_l1_port.sv
//**********************************************************
// Wishbone classic slave facing the L1 data cache
// Write cycles evict a line as add or switch, read cycles
// look a line up and end with err on a miss
// Ack and err come one cycle after stb is sampled, a full
// buffer without a hit withholds ack until an entry frees
//**********************************************************

`timescale 1ns/100ps

module wbb_l1_port import wbb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         wb1_cyc_i,
  input  logic         wb1_stb_i,
  input  logic         wb1_we_i,
  input  line_addr_t   wb1_adr_i,
  input  dcache_line_t wb1_dat_i,
  output dcache_line_t wb1_dat_o,
  output logic         wb1_ack_o,
  output logic         wb1_err_o,
  output wbb_l1_cmd_t  l1_cmd_o,
  input  dcache_line_t hit_line_i,
  input  wbb_status_t  status_i
);

  logic         req;
  logic         ack_q;
  logic         err_q;
  dcache_line_t rdata_q;

  // New request, the ack cycle of the last one is skipped
  assign req = wb1_cyc_i & wb1_stb_i & ~ack_q & ~err_q;

  // Address and line go straight to the buffer compare
  assign l1_cmd_o.line_addr = wb1_adr_i;
  assign l1_cmd_o.line      = wb1_dat_i;

  // Re-eviction of a buffered line replaces it in place
  assign l1_cmd_o.switch = req & wb1_we_i & status_i.line_hit;
  // Back-pressure, no add while full
  assign l1_cmd_o.add    = req & wb1_we_i & ~status_i.line_hit & ~status_i.full;
  assign l1_cmd_o.lookup = req & ~wb1_we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= l1_cmd_o.add | l1_cmd_o.switch | (l1_cmd_o.lookup & status_i.line_hit);
      err_q <= l1_cmd_o.lookup & ~status_i.line_hit;
    end
  end

  // Read data for a lookup hit
  always_ff @(posedge clk_i) begin
    if (l1_cmd_o.lookup && status_i.line_hit) begin
      rdata_q <= hit_line_i;
    end
  end

  assign wb1_ack_o = ack_q;
  assign wb1_err_o = err_q;
  assign wb1_dat_o = rdata_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb1_ack_o && wb1_err_o))
    else $error("L1 ack and err together");

  // L1 master keeps cyc up until the cycle ends
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb1_ack_o |-> wb1_cyc_i)
    else $error("L1 ack outside a cycle");

endmodule

//--- wbb_l2_master.sv
//**********************************************************
// Wishbone classic master that drains the victim buffer
// Issues the next ready entry with a fresh tag, writes it to
// L2 and answers ack with clear, err with wake
// Only one L2 write is in flight, the tag counter moves on
// once its clear or wake has been taken by the buffer
//**********************************************************

`timescale 1ns/100ps

module wbb_l2_master import wbb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  output logic         wb2_cyc_o,
  output logic         wb2_stb_o,
  output logic         wb2_we_o,
  output line_addr_t   wb2_adr_o,
  output dcache_line_t wb2_dat_o,
  output wbb_tag_t     wb2_tag_o,
  input  logic         wb2_ack_i,
  input  logic         wb2_err_i,
  output wbb_l2_cmd_t  l2_cmd_o,
  output wbb_tag_t     new_tag_o,
  input  logic         l2_cmd_taken_i,
  input  dcache_line_t req_line_i,
  input  line_addr_t   req_addr_i,
  input  wbb_status_t  status_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_BUS
  } state_t;

  state_t       state_q;
  wbb_tag_t     tag_cnt_q;
  wbb_tag_t     tag_q;
  line_addr_t   adr_q;
  dcache_line_t dat_q;
  logic         pend_clear_q;
  logic         pend_wake_q;
  logic         bus_ack;
  logic         bus_err;

  // Ack wins if the slave raises both
  assign bus_ack = (state_q == ST_BUS) & wb2_ack_i;
  assign bus_err = (state_q == ST_BUS) & wb2_err_i & ~wb2_ack_i;

  // Clear or wake goes out in the ending cycle, held if not taken
  assign l2_cmd_o.issue = (state_q == ST_ISSUE);
  assign l2_cmd_o.clear = bus_ack | pend_clear_q;
  assign l2_cmd_o.wake  = bus_err | pend_wake_q;
  assign l2_cmd_o.tag   = tag_q;
  assign new_tag_o      = tag_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      tag_cnt_q    <= '0;
      pend_clear_q <= 1'b0;
      pend_wake_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE:  if (!pend_clear_q && !pend_wake_q && status_i.req_available) state_q <= ST_ISSUE;
        ST_ISSUE: if (l2_cmd_taken_i) state_q <= ST_BUS;
        default:  if (wb2_ack_i || wb2_err_i) state_q <= ST_IDLE;
      endcase
      pend_clear_q <= l2_cmd_o.clear & ~l2_cmd_taken_i;
      pend_wake_q  <= l2_cmd_o.wake & ~l2_cmd_taken_i;
      // Next tag once the last write is retired
      if ((l2_cmd_o.clear || l2_cmd_o.wake) && l2_cmd_taken_i) begin
        tag_cnt_q <= tag_cnt_q + wbb_tag_t'(1);
      end
    end
  end

  // Request latched with the taken issue, stable for the whole write
  always_ff @(posedge clk_i) begin
    if (state_q == ST_ISSUE && l2_cmd_taken_i) begin
      adr_q <= req_addr_i;
      dat_q <= req_line_i;
      tag_q <= tag_cnt_q;
    end
  end

  assign wb2_cyc_o = (state_q == ST_BUS);
  assign wb2_stb_o = (state_q == ST_BUS);
  // Drain path only writes
  assign wb2_we_o  = 1'b1;
  assign wb2_adr_o = adr_q;
  assign wb2_dat_o = dat_q;
  assign wb2_tag_o = tag_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb2_stb_o && !wb2_ack_i && !wb2_err_i) |=>
      ($stable(wb2_adr_o) && $stable(wb2_dat_o) && $stable(wb2_tag_o)))
    else $error("L2 request changed before ack or err");

endmodule

//--- wbb_top.sv
//**********************************************************
// Top level of the L1 data cache write-back victim buffer
// L1 evicts and looks up lines over a Wishbone slave port,
// the buffer drains to L2 over a Wishbone master port
// full_o and free_entries_o report the buffer occupancy
//**********************************************************

`timescale 1ns/100ps

module wbb_top import wbb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // L1 side, Wishbone slave
  input  logic         wb1_cyc_i,
  input  logic         wb1_stb_i,
  input  logic         wb1_we_i,
  input  line_addr_t   wb1_adr_i,
  input  dcache_line_t wb1_dat_i,
  output dcache_line_t wb1_dat_o,
  output logic         wb1_ack_o,
  output logic         wb1_err_o,
  // L2 side, Wishbone master
  output logic         wb2_cyc_o,
  output logic         wb2_stb_o,
  output logic         wb2_we_o,
  output line_addr_t   wb2_adr_o,
  output dcache_line_t wb2_dat_o,
  output wbb_tag_t     wb2_tag_o,
  input  logic         wb2_ack_i,
  input  logic         wb2_err_i,
  // Occupancy
  output logic         full_o,
  output wbb_free_t    free_entries_o
);

  wbb_l1_cmd_t  l1_cmd;
  wbb_l2_cmd_t  l2_cmd;
  wbb_status_t  status;
  wbb_tag_t     new_tag;
  logic         l2_cmd_taken;
  dcache_line_t hit_line;
  dcache_line_t req_line;
  line_addr_t   req_addr;

  wbb_l1_port u_l1_port (
    .clk_i, .rst_ni,
    .wb1_cyc_i, .wb1_stb_i, .wb1_we_i, .wb1_adr_i, .wb1_dat_i,
    .wb1_dat_o, .wb1_ack_o, .wb1_err_o,
    .l1_cmd_o   (l1_cmd),
    .hit_line_i (hit_line),
    .status_i   (status)
  );

  wbb_buffer u_buffer (
    .clk_i, .rst_ni,
    .l1_cmd_i       (l1_cmd),
    .l2_cmd_i       (l2_cmd),
    .new_tag_i      (new_tag),
    .l2_cmd_taken_o (l2_cmd_taken),
    .hit_line_o     (hit_line),
    .req_line_o     (req_line),
    .req_addr_o     (req_addr),
    .status_o       (status)
  );

  wbb_l2_master u_l2_master (
    .clk_i, .rst_ni,
    .wb2_cyc_o, .wb2_stb_o, .wb2_we_o, .wb2_adr_o, .wb2_dat_o, .wb2_tag_o,
    .wb2_ack_i, .wb2_err_i,
    .l2_cmd_o       (l2_cmd),
    .new_tag_o      (new_tag),
    .l2_cmd_taken_i (l2_cmd_taken),
    .req_line_i     (req_line),
    .req_addr_i     (req_addr),
    .status_i       (status)
  );

  assign full_o         = status.full;
  assign free_entries_o = status.free_entries;

endmodule

//--- wbb_clk_gen.sv
//**********************************************************
// Clock and reset source for the victim buffer testbench
// 8 ns clock period, active-low reset held for 4 cycles
//**********************************************************

`timescale 1ns/100ps

module wbb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Half period of 4 ns
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release shortly after the fourth rising edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- wbb_tb.sv
//**********************************************************
// Testbench of the write-back victim buffer
// Plays a table of L1 evictions and lookups against the DUT,
// models the L2 slave with a per-step stall and a first-write
// error on odd addresses, then compares the L2 contents
//**********************************************************

`timescale 1ns/100ps

module wbb_tb import wbb_pkg::*; ();

  typedef enum logic [2:0] {OP_EVICT, OP_LOOKUP, OP_STALL, OP_WAIT_BUSY, OP_DRAIN} op_e;
  typedef enum logic [1:0] {RSP_ACK, RSP_ERR, RSP_BLOCK, RSP_NONE} rsp_e;

  // One table row
  // Field stall holds the L2 stall of OP_STALL or the release stall of a blocked eviction
  typedef struct packed {
    op_e          op;
    line_addr_t   adr;
    dcache_line_t data;
    rsp_e         rsp;
    dcache_line_t exp_data;
    logic [31:0]  stall;
    logic         chk_free;
    wbb_free_t    exp_free;
  } step_t;

  logic         clk;
  logic         rst_n;
  logic         wb1_cyc;
  logic         wb1_stb;
  logic         wb1_we;
  line_addr_t   wb1_adr;
  dcache_line_t wb1_dat_w;
  dcache_line_t wb1_dat_r;
  logic         wb1_ack;
  logic         wb1_err;
  logic         wb2_cyc;
  logic         wb2_stb;
  logic         wb2_we;
  line_addr_t   wb2_adr;
  dcache_line_t wb2_dat;
  wbb_tag_t     wb2_tag;
  logic         wb2_ack;
  logic         wb2_err;
  logic         full;
  wbb_free_t    free_entries;

  step_t        steps[$];
  // L2 model contents
  dcache_line_t l2_mem [line_addr_t];
  // Addresses that already failed once
  logic         err_done [line_addr_t];
  // Newest evicted line per address
  dcache_line_t last_line [line_addr_t];
  logic [31:0]  lcg_state;
  logic [31:0]  l2_stall;
  logic [31:0]  l2_wait;
  // Tag expected on the next finished L2 write
  wbb_tag_t     l2_tag_exp;
  logic         l2_tag_known;
  int           num_steps;
  int           errors;

  wbb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wbb_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .wb1_cyc_i      (wb1_cyc),
    .wb1_stb_i      (wb1_stb),
    .wb1_we_i       (wb1_we),
    .wb1_adr_i      (wb1_adr),
    .wb1_dat_i      (wb1_dat_w),
    .wb1_dat_o      (wb1_dat_r),
    .wb1_ack_o      (wb1_ack),
    .wb1_err_o      (wb1_err),
    .wb2_cyc_o      (wb2_cyc),
    .wb2_stb_o      (wb2_stb),
    .wb2_we_o       (wb2_we),
    .wb2_adr_o      (wb2_adr),
    .wb2_dat_o      (wb2_dat),
    .wb2_tag_o      (wb2_tag),
    .wb2_ack_i      (wb2_ack),
    .wb2_err_i      (wb2_err),
    .full_o         (full),
    .free_entries_o (free_entries)
  );

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(string name, dcache_line_t exp, dcache_line_t act);
    if (exp !== act) begin
      errors++;
      fail_run($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic dcache_line_t random_line();
    dcache_line_t line;
    for (int w = 0; w < LINE_BITS / 32; w++) begin
      line[w*32 +: 32] = lcg_next();
    end
    return line;
  endfunction

  // Negative exp_free skips the occupancy check
  task automatic add_ctrl(op_e op, logic [31:0] stall, int exp_free);
    steps.push_back('{op, '0, '0, RSP_NONE, '0, stall, exp_free >= 0, wbb_free_t'(exp_free)});
  endtask

  task automatic add_evict(line_addr_t adr, rsp_e rsp, logic [31:0] release_stall,
                           int exp_free);
    dcache_line_t line;
    line = random_line();
    last_line[adr] = line;
    steps.push_back('{OP_EVICT, adr, line, rsp, '0, release_stall, exp_free >= 0,
                      wbb_free_t'(exp_free)});
  endtask

  // Expected line is whatever was evicted last to that address
  task automatic add_lookup(line_addr_t adr, rsp_e rsp, int exp_free);
    dcache_line_t exp_line;
    exp_line = '0;
    if (last_line.exists(adr)) begin
      exp_line = last_line[adr];
    end
    steps.push_back('{OP_LOOKUP, adr, '0, rsp, exp_line, '0, exp_free >= 0,
                      wbb_free_t'(exp_free)});
  endtask

  task automatic build_table();
    // Stall of all ones holds L2 indefinitely
    add_ctrl(OP_STALL, 32'hffff_ffff, -1);
    add_evict(28'h000_0100, RSP_ACK, 0, 3);
    add_lookup(28'h000_0100, RSP_ACK, 3);
    add_lookup(28'h000_0200, RSP_ERR, 3);
    // Fill up so the fifth eviction waits for the L2 release
    add_evict(28'h000_0200, RSP_ACK, 0, 2);
    add_evict(28'h000_0300, RSP_ACK, 0, 1);
    add_evict(28'h000_0400, RSP_ACK, 0, 0);
    add_evict(28'h000_0500, RSP_BLOCK, 2, -1);
    add_ctrl(OP_DRAIN, 0, 4);
    // Re-eviction while the first write is in flight
    add_ctrl(OP_STALL, 32'hffff_ffff, -1);
    add_evict(28'h000_0600, RSP_ACK, 0, 3);
    add_ctrl(OP_WAIT_BUSY, 0, 3);
    add_evict(28'h000_0600, RSP_ACK, 0, 3);
    add_lookup(28'h000_0600, RSP_ACK, 3);
    add_ctrl(OP_STALL, 3, -1);
    add_ctrl(OP_DRAIN, 0, 4);
    // Odd addresses fail their first L2 write
    add_ctrl(OP_STALL, 32'hffff_ffff, -1);
    add_evict(28'h000_0701, RSP_ACK, 0, 3);
    add_evict(28'h000_0803, RSP_ACK, 0, 2);
    add_lookup(28'h000_0701, RSP_ACK, 2);
    add_ctrl(OP_STALL, 1, -1);
    add_ctrl(OP_DRAIN, 0, 4);
    // Drained address comes back with new data
    add_ctrl(OP_STALL, 0, -1);
    add_evict(28'h000_0200, RSP_ACK, 0, -1);
    add_ctrl(OP_DRAIN, 0, 4);
  endtask

  // One L1 Wishbone cycle that ends on the edge after ack or err
  task automatic l1_cycle(step_t s, string name);
    logic         got_ack;
    logic         got_err;
    dcache_line_t rdata;
    wb1_cyc   = 1'b1;
    wb1_stb   = 1'b1;
    wb1_we    = (s.op == OP_EVICT);
    wb1_adr   = s.adr;
    wb1_dat_w = s.data;
    got_ack   = 1'b0;
    got_err   = 1'b0;
    rdata     = '0;
    if (s.rsp == RSP_BLOCK) begin
      // Full buffer without a hit keeps the cycle open
      repeat (16) begin
        tick();
        check_value({name, " early response"}, '0, dcache_line_t'(wb1_ack | wb1_err));
        check_value({name, " full while blocked"}, 1, dcache_line_t'(full));
      end
      l2_stall = s.stall;
    end
    while (!got_ack && !got_err) begin
      tick();
      got_ack = wb1_ack;
      got_err = wb1_err;
      rdata   = wb1_dat_r;
    end
    tick();
    wb1_cyc = 1'b0;
    wb1_stb = 1'b0;
    wb1_we  = 1'b0;
    check_value({name, " ack"}, dcache_line_t'(s.rsp != RSP_ERR), dcache_line_t'(got_ack));
    check_value({name, " err"}, dcache_line_t'(s.rsp == RSP_ERR), dcache_line_t'(got_err));
    if (s.op == OP_LOOKUP && s.rsp == RSP_ACK) begin
      check_value({name, " data"}, s.exp_data, rdata);
    end
  endtask

  task automatic run_step(int idx, step_t s);
    op_e   op;
    string name;
    op   = s.op;
    name = $sformatf("step %0d %s", idx, op.name());
    case (op)
      OP_STALL: begin
        l2_stall = s.stall;
        tick();
      end
      OP_WAIT_BUSY: begin
        while (!(wb2_cyc && wb2_stb)) tick();
      end
      OP_DRAIN: begin
        while (free_entries != wbb_free_t'(WBB_ENTRIES) || wb2_cyc) tick();
      end
      default: begin
        l1_cycle(s, name);
      end
    endcase
    if (s.chk_free) begin
      check_value({name, " free entries"}, dcache_line_t'(s.exp_free),
                  dcache_line_t'(free_entries));
      check_value({name, " full"}, dcache_line_t'(s.exp_free == '0), dcache_line_t'(full));
    end
  endtask

  // L2 slave model that stores on ack and errs on the first write to an odd address
  initial begin
    wb2_ack      = 1'b0;
    wb2_err      = 1'b0;
    l2_wait      = '0;
    l2_tag_exp   = '0;
    l2_tag_known = 1'b0;
    forever begin
      tick();
      if (wb2_ack || wb2_err) begin
        wb2_ack = 1'b0;
        wb2_err = 1'b0;
      end else if (wb2_cyc && wb2_stb) begin
        check_value("L2 write enable", 1, dcache_line_t'(wb2_we));
        if (l2_wait >= l2_stall) begin
          l2_wait = '0;
          // Every finished write moves the tag on by one
          if (!l2_tag_known) begin
            l2_tag_exp   = wb2_tag;
            l2_tag_known = 1'b1;
          end
          check_value("L2 tag", dcache_line_t'(l2_tag_exp), dcache_line_t'(wb2_tag));
          l2_tag_exp = l2_tag_exp + wbb_tag_t'(1);
          if (wb2_adr[0] && !err_done.exists(wb2_adr)) begin
            err_done[wb2_adr] = 1'b1;
            wb2_err = 1'b1;
          end else begin
            l2_mem[wb2_adr] = wb2_dat;
            wb2_ack = 1'b1;
          end
        end else begin
          l2_wait = l2_wait + 32'd1;
        end
      end
    end
  end

  // Budget of 200 cycles per table step
  initial begin
    wait (num_steps > 0);
    repeat (num_steps * 200) @(posedge clk);
    fail_run($sformatf("Timeout, the table did not finish within %0d cycles",
                       num_steps * 200));
  end

  initial begin
    wb1_cyc   = 1'b0;
    wb1_stb   = 1'b0;
    wb1_we    = 1'b0;
    wb1_adr   = '0;
    wb1_dat_w = '0;
    l2_stall  = '0;
    errors    = 0;
    lcg_state = 32'ha72a_67f2;
    build_table();
    num_steps = steps.size();
    wait (rst_n === 1'b1);
    tick();
    // Idle state right after reset
    check_value("reset free entries", dcache_line_t'(WBB_ENTRIES),
                dcache_line_t'(free_entries));
    check_value("reset full", '0, dcache_line_t'(full));
    check_value("reset L2 cyc", '0, dcache_line_t'(wb2_cyc | wb2_stb));
    check_value("reset L1 response", '0, dcache_line_t'(wb1_ack | wb1_err));
    for (int i = 0; i < num_steps; i++) begin
      run_step(i, steps[i]);
    end
    // Every evicted address ends up in L2 with its newest line
    foreach (last_line[a]) begin
      if (l2_mem.exists(a)) begin
        check_value($sformatf("L2 line %h", a), last_line[a], l2_mem[a]);
      end else begin
        fail_run($sformatf("Address %h never reached the L2 model", a));
      end
    end
    if (errors == 0) begin
      $display("No errors");
      $finish;
    end else begin
      fail_run("Checks failed before the end of the table");
    end
  end

endmodule

//--- vlog.f
wbb_pkg.sv
wbb_prio_encoder.sv
wbb_buffer.sv
wbb_l1_port.sv
wbb_l2_master.sv
wbb_top.sv
wbb_clk_gen.sv
wbb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the victim buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module wbb_tb -f vlog.f -o wbb_sim
# The log decides the result, not the exit status of the run
./obj_dir/wbb_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
